// File: Makefile
VERILATOR ?= verilator
TOP       := axi_read_xbar_tb
FILELIST  := sim.f
FLAGS     := --timing --assert
OBJDIR    := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: sim.f
source/axi_read_pkg.sv
source/slave_arbiter.sv
source/slave_port_mux.sv
source/master_return_mux.sv
source/axi_read_xbar.sv
verification/axi_read_xbar_props.sv
verification/axi_read_xbar_tb.sv

// File: source/axi_read_pkg.sv
package axi_read_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 8;
    localparam int LEN_W  = 8;
    localparam int RESP_W = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [RESP_W-1:0] resp_t;

    // Slave 2 window starts here, slave 1 owns everything below
    localparam addr_t S2_BASE = 32'h8000_0000;

    // One-hot master select, bit 0 is master 1 and bit 1 is master 2
    typedef logic [1:0] grant_t;

    localparam grant_t GRANT_NONE = 2'b00;
    localparam grant_t GRANT_M1   = 2'b01;
    localparam grant_t GRANT_M2   = 2'b10;

    // Arbiter states
    // ARB_ADDR lasts until the AR handshake, ARB_DATA until the last R beat
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_DATA
    } arb_state_t;

endpackage

// File: source/axi_read_xbar.sv
module axi_read_xbar (
    input  logic                i_clk,
    input  logic                i_arst_n,

    // Master 1
    input  axi_read_pkg::addr_t i_m1_araddr,
    input  axi_read_pkg::id_t   i_m1_arid,
    input  axi_read_pkg::len_t  i_m1_arlen,
    input  logic                i_m1_arvalid,
    output logic                o_m1_arready,
    output axi_read_pkg::id_t   o_m1_rid,
    output axi_read_pkg::data_t o_m1_rdata,
    output axi_read_pkg::resp_t o_m1_rresp,
    output logic                o_m1_rlast,
    output logic                o_m1_rvalid,
    input  logic                i_m1_rready,

    // Master 2
    input  axi_read_pkg::addr_t i_m2_araddr,
    input  axi_read_pkg::id_t   i_m2_arid,
    input  axi_read_pkg::len_t  i_m2_arlen,
    input  logic                i_m2_arvalid,
    output logic                o_m2_arready,
    output axi_read_pkg::id_t   o_m2_rid,
    output axi_read_pkg::data_t o_m2_rdata,
    output axi_read_pkg::resp_t o_m2_rresp,
    output logic                o_m2_rlast,
    output logic                o_m2_rvalid,
    input  logic                i_m2_rready,

    // Slave 1
    output axi_read_pkg::addr_t o_s1_araddr,
    output axi_read_pkg::id_t   o_s1_arid,
    output axi_read_pkg::len_t  o_s1_arlen,
    output logic                o_s1_arvalid,
    input  logic                i_s1_arready,
    input  axi_read_pkg::id_t   i_s1_rid,
    input  axi_read_pkg::data_t i_s1_rdata,
    input  axi_read_pkg::resp_t i_s1_rresp,
    input  logic                i_s1_rlast,
    input  logic                i_s1_rvalid,
    output logic                o_s1_rready,

    // Slave 2
    output axi_read_pkg::addr_t o_s2_araddr,
    output axi_read_pkg::id_t   o_s2_arid,
    output axi_read_pkg::len_t  o_s2_arlen,
    output logic                o_s2_arvalid,
    input  logic                i_s2_arready,
    input  axi_read_pkg::id_t   i_s2_rid,
    input  axi_read_pkg::data_t i_s2_rdata,
    input  axi_read_pkg::resp_t i_s2_rresp,
    input  logic                i_s2_rlast,
    input  logic                i_s2_rvalid,
    output logic                o_s2_rready
);

    axi_read_pkg::grant_t s1_addr_grant;
    axi_read_pkg::grant_t s1_data_grant;
    axi_read_pkg::grant_t s2_addr_grant;
    axi_read_pkg::grant_t s2_data_grant;

    // One arbiter per slave
    slave_arbiter #(.SLAVE_HI(1'b0)) arb_s1 (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_m1_araddr  (i_m1_araddr),
        .i_m2_araddr  (i_m2_araddr),
        .i_m1_arvalid (i_m1_arvalid),
        .i_m2_arvalid (i_m2_arvalid),
        .i_s_arready  (i_s1_arready),
        .i_s_rvalid   (i_s1_rvalid),
        .i_s_rlast    (i_s1_rlast),
        .i_s_rready   (o_s1_rready),
        .o_addr_grant (s1_addr_grant),
        .o_data_grant (s1_data_grant)
    );

    slave_arbiter #(.SLAVE_HI(1'b1)) arb_s2 (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_m1_araddr  (i_m1_araddr),
        .i_m2_araddr  (i_m2_araddr),
        .i_m1_arvalid (i_m1_arvalid),
        .i_m2_arvalid (i_m2_arvalid),
        .i_s_arready  (i_s2_arready),
        .i_s_rvalid   (i_s2_rvalid),
        .i_s_rlast    (i_s2_rlast),
        .i_s_rready   (o_s2_rready),
        .o_addr_grant (s2_addr_grant),
        .o_data_grant (s2_data_grant)
    );

    // Forward path to each slave
    slave_port_mux #(.SLAVE_HI(1'b0)) port_s1 (
        .i_addr_grant (s1_addr_grant),
        .i_data_grant (s1_data_grant),
        .i_m1_araddr  (i_m1_araddr),
        .i_m2_araddr  (i_m2_araddr),
        .i_m1_arid    (i_m1_arid),
        .i_m2_arid    (i_m2_arid),
        .i_m1_arlen   (i_m1_arlen),
        .i_m2_arlen   (i_m2_arlen),
        .i_m1_arvalid (i_m1_arvalid),
        .i_m2_arvalid (i_m2_arvalid),
        .i_m1_rready  (i_m1_rready),
        .i_m2_rready  (i_m2_rready),
        .o_s_araddr   (o_s1_araddr),
        .o_s_arid     (o_s1_arid),
        .o_s_arlen    (o_s1_arlen),
        .o_s_arvalid  (o_s1_arvalid),
        .o_s_rready   (o_s1_rready)
    );

    slave_port_mux #(.SLAVE_HI(1'b1)) port_s2 (
        .i_addr_grant (s2_addr_grant),
        .i_data_grant (s2_data_grant),
        .i_m1_araddr  (i_m1_araddr),
        .i_m2_araddr  (i_m2_araddr),
        .i_m1_arid    (i_m1_arid),
        .i_m2_arid    (i_m2_arid),
        .i_m1_arlen   (i_m1_arlen),
        .i_m2_arlen   (i_m2_arlen),
        .i_m1_arvalid (i_m1_arvalid),
        .i_m2_arvalid (i_m2_arvalid),
        .i_m1_rready  (i_m1_rready),
        .i_m2_rready  (i_m2_rready),
        .o_s_araddr   (o_s2_araddr),
        .o_s_arid     (o_s2_arid),
        .o_s_arlen    (o_s2_arlen),
        .o_s_arvalid  (o_s2_arvalid),
        .o_s_rready   (o_s2_rready)
    );

    // Return path to each master
    master_return_mux #(.MASTER_BIT(0)) ret_m1 (
        .i_s1_addr_grant (s1_addr_grant),
        .i_s2_addr_grant (s2_addr_grant),
        .i_s1_data_grant (s1_data_grant),
        .i_s2_data_grant (s2_data_grant),
        .i_s1_arready    (i_s1_arready),
        .i_s2_arready    (i_s2_arready),
        .i_s1_rid        (i_s1_rid),
        .i_s2_rid        (i_s2_rid),
        .i_s1_rdata      (i_s1_rdata),
        .i_s2_rdata      (i_s2_rdata),
        .i_s1_rresp      (i_s1_rresp),
        .i_s2_rresp      (i_s2_rresp),
        .i_s1_rlast      (i_s1_rlast),
        .i_s2_rlast      (i_s2_rlast),
        .i_s1_rvalid     (i_s1_rvalid),
        .i_s2_rvalid     (i_s2_rvalid),
        .o_arready       (o_m1_arready),
        .o_rid           (o_m1_rid),
        .o_rdata         (o_m1_rdata),
        .o_rresp         (o_m1_rresp),
        .o_rlast         (o_m1_rlast),
        .o_rvalid        (o_m1_rvalid)
    );

    master_return_mux #(.MASTER_BIT(1)) ret_m2 (
        .i_s1_addr_grant (s1_addr_grant),
        .i_s2_addr_grant (s2_addr_grant),
        .i_s1_data_grant (s1_data_grant),
        .i_s2_data_grant (s2_data_grant),
        .i_s1_arready    (i_s1_arready),
        .i_s2_arready    (i_s2_arready),
        .i_s1_rid        (i_s1_rid),
        .i_s2_rid        (i_s2_rid),
        .i_s1_rdata      (i_s1_rdata),
        .i_s2_rdata      (i_s2_rdata),
        .i_s1_rresp      (i_s1_rresp),
        .i_s2_rresp      (i_s2_rresp),
        .i_s1_rlast      (i_s1_rlast),
        .i_s2_rlast      (i_s2_rlast),
        .i_s1_rvalid     (i_s1_rvalid),
        .i_s2_rvalid     (i_s2_rvalid),
        .o_arready       (o_m2_arready),
        .o_rid           (o_m2_rid),
        .o_rdata         (o_m2_rdata),
        .o_rresp         (o_m2_rresp),
        .o_rlast         (o_m2_rlast),
        .o_rvalid        (o_m2_rvalid)
    );

endmodule

// File: source/master_return_mux.sv
module master_return_mux #(
    parameter int MASTER_BIT = 0
) (
    input  axi_read_pkg::grant_t i_s1_addr_grant,
    input  axi_read_pkg::grant_t i_s2_addr_grant,
    input  axi_read_pkg::grant_t i_s1_data_grant,
    input  axi_read_pkg::grant_t i_s2_data_grant,
    input  logic                 i_s1_arready,
    input  logic                 i_s2_arready,
    input  axi_read_pkg::id_t    i_s1_rid,
    input  axi_read_pkg::id_t    i_s2_rid,
    input  axi_read_pkg::data_t  i_s1_rdata,
    input  axi_read_pkg::data_t  i_s2_rdata,
    input  axi_read_pkg::resp_t  i_s1_rresp,
    input  axi_read_pkg::resp_t  i_s2_rresp,
    input  logic                 i_s1_rlast,
    input  logic                 i_s2_rlast,
    input  logic                 i_s1_rvalid,
    input  logic                 i_s2_rvalid,
    output logic                 o_arready,
    output axi_read_pkg::id_t    o_rid,
    output axi_read_pkg::data_t  o_rdata,
    output axi_read_pkg::resp_t  o_rresp,
    output logic                 o_rlast,
    output logic                 o_rvalid
);

    // arready only from a slave whose address phase belongs to us
    always_comb begin
        if (i_s1_addr_grant[MASTER_BIT]) begin
            o_arready = i_s1_arready;
        end else if (i_s2_addr_grant[MASTER_BIT]) begin
            o_arready = i_s2_arready;
        end else begin
            o_arready = 1'b0;
        end
    end

    // One read outstanding per master, so at most one slave matches here
    always_comb begin
        o_rid    = '0;
        o_rdata  = '0;
        o_rresp  = '0;
        o_rlast  = 1'b0;
        o_rvalid = 1'b0;
        if (i_s1_data_grant[MASTER_BIT]) begin
            o_rid    = i_s1_rid;
            o_rdata  = i_s1_rdata;
            o_rresp  = i_s1_rresp;
            o_rlast  = i_s1_rlast;
            o_rvalid = i_s1_rvalid;
        end else if (i_s2_data_grant[MASTER_BIT]) begin
            o_rid    = i_s2_rid;
            o_rdata  = i_s2_rdata;
            o_rresp  = i_s2_rresp;
            o_rlast  = i_s2_rlast;
            o_rvalid = i_s2_rvalid;
        end
    end

endmodule

// File: source/slave_arbiter.sv
module slave_arbiter #(
    parameter bit SLAVE_HI = 1'b0
) (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  axi_read_pkg::addr_t  i_m1_araddr,
    input  axi_read_pkg::addr_t  i_m2_araddr,
    input  logic                 i_m1_arvalid,
    input  logic                 i_m2_arvalid,
    input  logic                 i_s_arready,
    input  logic                 i_s_rvalid,
    input  logic                 i_s_rlast,
    input  logic                 i_s_rready,
    output axi_read_pkg::grant_t o_addr_grant,
    output axi_read_pkg::grant_t o_data_grant
);

    logic                     m1_hi;
    logic                     m2_hi;
    logic                     m1_req;
    logic                     m2_req;
    logic                     ar_hs;
    logic                     r_last_hs;
    axi_read_pkg::grant_t     winner;
    axi_read_pkg::grant_t     grant_q;
    axi_read_pkg::grant_t     last_q;
    axi_read_pkg::arb_state_t state_q;

    // Window decode for each master
    assign m1_hi  = i_m1_araddr >= axi_read_pkg::S2_BASE;
    assign m2_hi  = i_m2_araddr >= axi_read_pkg::S2_BASE;
    assign m1_req = i_m1_arvalid && (m1_hi == SLAVE_HI);
    assign m2_req = i_m2_arvalid && (m2_hi == SLAVE_HI);

    // Round-robin pick, the master not served last time wins a tie
    always_comb begin
        if (m1_req && m2_req) begin
            if (last_q == axi_read_pkg::GRANT_M1) begin
                winner = axi_read_pkg::GRANT_M2;
            end else begin
                winner = axi_read_pkg::GRANT_M1;
            end
        end else if (m1_req) begin
            winner = axi_read_pkg::GRANT_M1;
        end else if (m2_req) begin
            winner = axi_read_pkg::GRANT_M2;
        end else begin
            winner = axi_read_pkg::GRANT_NONE;
        end
    end

    // AR handshake of the granted master
    assign ar_hs     = i_s_arready && |(grant_q & {i_m2_arvalid, i_m1_arvalid});
    assign r_last_hs = i_s_rvalid && i_s_rready && i_s_rlast;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= axi_read_pkg::ARB_IDLE;
            grant_q <= axi_read_pkg::GRANT_NONE;
            // Pretend master 2 went last so master 1 takes the first tie
            last_q  <= axi_read_pkg::GRANT_M2;
        end else begin
            case (state_q)
                axi_read_pkg::ARB_IDLE: begin
                    if (winner != axi_read_pkg::GRANT_NONE) begin
                        state_q <= axi_read_pkg::ARB_ADDR;
                        grant_q <= winner;
                        last_q  <= winner;
                    end
                end
                axi_read_pkg::ARB_ADDR: begin
                    if (ar_hs) begin
                        state_q <= axi_read_pkg::ARB_DATA;
                    end
                end
                axi_read_pkg::ARB_DATA: begin
                    // Hold the grant until the final beat is taken
                    if (r_last_hs) begin
                        state_q <= axi_read_pkg::ARB_IDLE;
                        grant_q <= axi_read_pkg::GRANT_NONE;
                    end
                end
                default: begin
                    state_q <= axi_read_pkg::ARB_IDLE;
                    grant_q <= axi_read_pkg::GRANT_NONE;
                end
            endcase
        end
    end

    assign o_addr_grant = (state_q == axi_read_pkg::ARB_ADDR) ? grant_q
                                                               : axi_read_pkg::GRANT_NONE;
    assign o_data_grant = (state_q == axi_read_pkg::ARB_DATA) ? grant_q
                                                               : axi_read_pkg::GRANT_NONE;

endmodule

// File: source/slave_port_mux.sv
module slave_port_mux #(
    parameter bit SLAVE_HI = 1'b0
) (
    input  axi_read_pkg::grant_t i_addr_grant,
    input  axi_read_pkg::grant_t i_data_grant,
    input  axi_read_pkg::addr_t  i_m1_araddr,
    input  axi_read_pkg::addr_t  i_m2_araddr,
    input  axi_read_pkg::id_t    i_m1_arid,
    input  axi_read_pkg::id_t    i_m2_arid,
    input  axi_read_pkg::len_t   i_m1_arlen,
    input  axi_read_pkg::len_t   i_m2_arlen,
    input  logic                 i_m1_arvalid,
    input  logic                 i_m2_arvalid,
    input  logic                 i_m1_rready,
    input  logic                 i_m2_rready,
    output axi_read_pkg::addr_t  o_s_araddr,
    output axi_read_pkg::id_t    o_s_arid,
    output axi_read_pkg::len_t   o_s_arlen,
    output logic                 o_s_arvalid,
    output logic                 o_s_rready
);

    // Slave 2 sees addresses relative to its own base
    localparam axi_read_pkg::addr_t OFFSET = SLAVE_HI ? axi_read_pkg::S2_BASE : '0;

    // AR channel follows the address grant
    always_comb begin
        case (i_addr_grant)
            axi_read_pkg::GRANT_M1: begin
                o_s_araddr  = i_m1_araddr - OFFSET;
                o_s_arid    = i_m1_arid;
                o_s_arlen   = i_m1_arlen;
                o_s_arvalid = i_m1_arvalid;
            end
            axi_read_pkg::GRANT_M2: begin
                o_s_araddr  = i_m2_araddr - OFFSET;
                o_s_arid    = i_m2_arid;
                o_s_arlen   = i_m2_arlen;
                o_s_arvalid = i_m2_arvalid;
            end
            default: begin
                o_s_araddr  = '0;
                o_s_arid    = '0;
                o_s_arlen   = '0;
                o_s_arvalid = 1'b0;
            end
        endcase
    end

    // rready follows the data grant
    always_comb begin
        case (i_data_grant)
            axi_read_pkg::GRANT_M1: o_s_rready = i_m1_rready;
            axi_read_pkg::GRANT_M2: o_s_rready = i_m2_rready;
            default:                o_s_rready = 1'b0;
        endcase
    end

endmodule

// File: verification/axi_read_xbar_props.sv
module axi_read_xbar_props (
    input logic                 i_clk,
    input logic                 i_arst_n,
    input axi_read_pkg::grant_t i_s1_addr_grant,
    input axi_read_pkg::grant_t i_s1_data_grant,
    input axi_read_pkg::grant_t i_s2_addr_grant,
    input axi_read_pkg::grant_t i_s2_data_grant,
    input logic                 i_s1_arvalid,
    input logic                 i_s1_arready,
    input logic                 i_s2_arvalid,
    input logic                 i_s2_arready
);

    // One-hot over both phases, so each grant is one-hot and never both at once
    s1_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({i_s1_addr_grant, i_s1_data_grant}))
        else $error("Slave 1 grants are not one-hot or overlap");

    s2_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({i_s2_addr_grant, i_s2_data_grant}))
        else $error("Slave 2 grants are not one-hot or overlap");

    // A forwarded request is held until the slave takes it
    s1_arvalid_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_s1_arvalid && !i_s1_arready |=> i_s1_arvalid)
        else $error("Slave 1 arvalid dropped before arready");

    s2_arvalid_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_s2_arvalid && !i_s2_arready |=> i_s2_arvalid)
        else $error("Slave 2 arvalid dropped before arready");

endmodule

bind axi_read_xbar axi_read_xbar_props props_i (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_s1_addr_grant (s1_addr_grant),
    .i_s1_data_grant (s1_data_grant),
    .i_s2_addr_grant (s2_addr_grant),
    .i_s2_data_grant (s2_data_grant),
    .i_s1_arvalid    (o_s1_arvalid),
    .i_s1_arready    (i_s1_arready),
    .i_s2_arvalid    (o_s2_arvalid),
    .i_s2_arready    (i_s2_arready)
);

// File: verification/axi_read_xbar_tb.sv
module axi_read_xbar_tb;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 5;
    localparam int          NUM_READS    = 60;
    localparam int          WAIT_LIMIT   = 2000;
    localparam int          RUN_LIMIT    = 100000;
    localparam logic [31:0] SEED         = 32'hb8fa_0e2f;
    // Data keys that tell the two slaves apart
    localparam axi_read_pkg::data_t S1_KEY = 32'h5a5a_0000;
    localparam axi_read_pkg::data_t S2_KEY = 32'hc3c3_0000;

    logic clk;
    logic arst_n;

    // Index 0 is master/slave 1 and index 1 is master/slave 2
    logic [1:0]          m_arvalid, m_arready, m_rready, m_rvalid, m_rlast;
    axi_read_pkg::addr_t m_araddr [2];
    axi_read_pkg::id_t   m_arid [2];
    axi_read_pkg::id_t   m_rid [2];
    axi_read_pkg::len_t  m_arlen [2];
    axi_read_pkg::data_t m_rdata [2];
    axi_read_pkg::resp_t m_rresp [2];

    logic [1:0]          s_arvalid, s_arready, s_rready, s_rvalid, s_rlast;
    axi_read_pkg::addr_t s_araddr [2];
    axi_read_pkg::id_t   s_arid [2];
    axi_read_pkg::id_t   s_rid [2];
    axi_read_pkg::len_t  s_arlen [2];
    axi_read_pkg::data_t s_rdata [2];
    axi_read_pkg::resp_t s_rresp [2];

    // Scoreboard state of the one outstanding read per master
    int                  issued [2];
    int                  completed [2];
    int                  beat_cnt [2];
    int                  exp_slave [2];
    axi_read_pkg::addr_t exp_local [2];
    axi_read_pkg::id_t   exp_id [2];
    axi_read_pkg::len_t  exp_len [2];
    bit                  done [2];

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Beat n of a read at slave-local address a
    function automatic axi_read_pkg::data_t expected_beat(input int slave,
                                                         input axi_read_pkg::addr_t a,
                                                         input int n);
        axi_read_pkg::data_t key;
        key = (slave == 0) ? S1_KEY : S2_KEY;
        return (a + 32'(4 * n)) ^ key;
    endfunction

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        stop_with_failure();
    endtask

    always #(CLK_PERIOD / 2) clk = ~clk;

    axi_read_xbar axi_read_xbar_i (
        .i_clk        (clk),
        .i_arst_n     (arst_n),
        .i_m1_araddr  (m_araddr[0]),
        .i_m1_arid    (m_arid[0]),
        .i_m1_arlen   (m_arlen[0]),
        .i_m1_arvalid (m_arvalid[0]),
        .o_m1_arready (m_arready[0]),
        .o_m1_rid     (m_rid[0]),
        .o_m1_rdata   (m_rdata[0]),
        .o_m1_rresp   (m_rresp[0]),
        .o_m1_rlast   (m_rlast[0]),
        .o_m1_rvalid  (m_rvalid[0]),
        .i_m1_rready  (m_rready[0]),
        .i_m2_araddr  (m_araddr[1]),
        .i_m2_arid    (m_arid[1]),
        .i_m2_arlen   (m_arlen[1]),
        .i_m2_arvalid (m_arvalid[1]),
        .o_m2_arready (m_arready[1]),
        .o_m2_rid     (m_rid[1]),
        .o_m2_rdata   (m_rdata[1]),
        .o_m2_rresp   (m_rresp[1]),
        .o_m2_rlast   (m_rlast[1]),
        .o_m2_rvalid  (m_rvalid[1]),
        .i_m2_rready  (m_rready[1]),
        .o_s1_araddr  (s_araddr[0]),
        .o_s1_arid    (s_arid[0]),
        .o_s1_arlen   (s_arlen[0]),
        .o_s1_arvalid (s_arvalid[0]),
        .i_s1_arready (s_arready[0]),
        .i_s1_rid     (s_rid[0]),
        .i_s1_rdata   (s_rdata[0]),
        .i_s1_rresp   (s_rresp[0]),
        .i_s1_rlast   (s_rlast[0]),
        .i_s1_rvalid  (s_rvalid[0]),
        .o_s1_rready  (s_rready[0]),
        .o_s2_araddr  (s_araddr[1]),
        .o_s2_arid    (s_arid[1]),
        .o_s2_arlen   (s_arlen[1]),
        .o_s2_arvalid (s_arvalid[1]),
        .i_s2_arready (s_arready[1]),
        .i_s2_rid     (s_rid[1]),
        .i_s2_rdata   (s_rdata[1]),
        .i_s2_rresp   (s_rresp[1]),
        .i_s2_rlast   (s_rlast[1]),
        .i_s2_rvalid  (s_rvalid[1]),
        .o_s2_rready  (s_rready[1])
    );

    // Slave models with random arready and random gaps between beats
    for (genvar s = 0; s < 2; s++) begin : g_slave
        initial begin
            logic [31:0]         st;
            axi_read_pkg::addr_t a;
            axi_read_pkg::id_t   id;
            axi_read_pkg::len_t  len;
            int                  n;
            int                  guard;
            bit                  took;
            st = SEED ^ (32'h1357_9bdf * 32'(s + 1));
            s_arready[s] = 1'b1;
            s_rvalid[s]  = 1'b1;
            s_rlast[s]   = 1'b0;
            s_rid[s]     = '0;
            s_rdata[s]   = '0;
            s_rresp[s]   = '0;
            // Ready and valid stay high while the crossbar is in reset
            repeat (RESET_CYCLES - 1) @(negedge clk);
            forever begin
                guard = 0;
                do begin
                    @(negedge clk);
                    s_rvalid[s]  = 1'b0;
                    s_rlast[s]   = 1'b0;
                    st           = xorshift(st);
                    s_arready[s] = st[0];
                    @(posedge clk);
                    guard++;
                    if (guard > WAIT_LIMIT) begin
                        report_failure($sformatf("Slave %0d got no read address", s + 1));
                    end
                end while (!(s_arvalid[s] && s_arready[s]));
                a     = s_araddr[s];
                id    = s_arid[s];
                len   = s_arlen[s];
                n     = 0;
                took  = 1'b0;
                guard = 0;
                while (n <= int'(len)) begin
                    @(negedge clk);
                    s_arready[s] = 1'b0;
                    if (took) s_rvalid[s] = 1'b0;
                    st = xorshift(st);
                    if (!s_rvalid[s] && st[1:0] != 2'b00) begin
                        s_rvalid[s] = 1'b1;
                        s_rid[s]    = id;
                        s_rdata[s]  = expected_beat(s, a, n);
                        s_rresp[s]  = '0;
                        s_rlast[s]  = (n == int'(len));
                    end
                    @(posedge clk);
                    took = s_rvalid[s] && s_rready[s];
                    if (took) n++;
                    guard++;
                    if (guard > WAIT_LIMIT) begin
                        report_failure($sformatf("Slave %0d burst was never drained", s + 1));
                    end
                end
            end
        end
    end

    for (genvar m = 0; m < 2; m++) begin : g_master
        // Random reads with one outstanding at a time
        initial begin
            logic [31:0]         st;
            axi_read_pkg::addr_t addr;
            logic                hi;
            int                  guard;
            st           = SEED ^ (32'h2468_ace1 * 32'(m + 1));
            m_araddr[m]  = (m == 1) ? axi_read_pkg::S2_BASE : '0;
            m_arid[m]    = '0;
            m_arlen[m]   = '0;
            m_arvalid[m] = 1'b1;
            m_rready[m]  = 1'b1;
            issued[m]    = 0;
            exp_slave[m] = 0;
            exp_local[m] = '0;
            exp_id[m]    = '0;
            exp_len[m]   = '0;
            done[m]      = 1'b0;
            // Requests held through reset must not be granted
            repeat (RESET_CYCLES) @(negedge clk);
            m_arvalid[m] = 1'b0;
            m_rready[m]  = 1'b0;
            @(negedge clk);
            for (int i = 0; i < NUM_READS; i++) begin
                st = xorshift(st);
                // Parallel paths first and shared slaves next before mixed traffic
                if (i < 8) hi = (m == 1);
                else if (i < 24) hi = ((i / 4) % 2) == 1;
                else hi = st[31];
                addr         = {hi, st[30:2], 2'b00};
                st           = xorshift(st);
                m_araddr[m]  = addr;
                m_arid[m]    = st[7:0];
                m_arlen[m]   = {6'd0, st[9:8]};
                m_arvalid[m] = 1'b1;
                m_rready[m]  = 1'b0;
                guard        = 0;
                do begin
                    @(posedge clk);
                    guard++;
                    if (guard > WAIT_LIMIT) begin
                        report_failure($sformatf("Master %0d address was never accepted", m + 1));
                    end
                end while (!m_arready[m]);
                if (addr >= axi_read_pkg::S2_BASE) begin
                    exp_slave[m] = 1;
                    exp_local[m] = addr - axi_read_pkg::S2_BASE;
                end else begin
                    exp_slave[m] = 0;
                    exp_local[m] = addr;
                end
                exp_id[m]  = m_arid[m];
                exp_len[m] = m_arlen[m];
                issued[m]++;
                guard = 0;
                while (completed[m] != issued[m]) begin
                    @(negedge clk);
                    m_arvalid[m] = 1'b0;
                    st           = xorshift(st);
                    m_rready[m]  = st[1:0] != 2'b00;
                    guard++;
                    if (guard > WAIT_LIMIT) begin
                        report_failure($sformatf("Master %0d read never completed", m + 1));
                    end
                end
            end
            m_rready[m] = 1'b0;
            done[m]     = 1'b1;
        end

        // Checks every R handshake seen by this master
        always @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                completed[m] <= 0;
                beat_cnt[m]  <= 0;
            end else if (m_rvalid[m] && m_rready[m]) begin
                assert (issued[m] != completed[m])
                    else report_failure($sformatf("Master %0d got a beat it never asked for",
                                                  m + 1));
                assert (m_rid[m] == exp_id[m])
                    else report_mismatch($sformatf("o_m%0d_rid", m + 1),
                                         32'(m_rid[m]), 32'(exp_id[m]));
                assert (m_rdata[m] == expected_beat(exp_slave[m], exp_local[m], beat_cnt[m]))
                    else report_mismatch($sformatf("o_m%0d_rdata", m + 1), m_rdata[m],
                                         expected_beat(exp_slave[m], exp_local[m],
                                                       beat_cnt[m]));
                assert (m_rresp[m] == 2'b00)
                    else report_mismatch($sformatf("o_m%0d_rresp", m + 1),
                                         32'(m_rresp[m]), 32'h0);
                assert (m_rlast[m] == (beat_cnt[m] == int'(exp_len[m])))
                    else report_mismatch($sformatf("o_m%0d_rlast", m + 1), 32'(m_rlast[m]),
                                         32'(beat_cnt[m] == int'(exp_len[m])));
                if (m_rlast[m]) begin
                    beat_cnt[m]  <= 0;
                    completed[m] <= completed[m] + 1;
                end else begin
                    beat_cnt[m] <= beat_cnt[m] + 1;
                end
            end
        end
    end

    initial begin
        int guard;
        clk    = 1'b0;
        arst_n = 1'b0;
        // Masters and slaves drive their valids and readies high during reset
        repeat (RESET_CYCLES - 1) @(negedge clk);
        assert ((m_arready | m_rvalid | s_arvalid | s_rready) == 2'b00)
            else report_failure("Handshake outputs are not low during reset");
        @(negedge clk);
        arst_n = 1'b1;
        guard  = 0;
        while (!(done[0] && done[1]) && guard < RUN_LIMIT) begin
            @(negedge clk);
            guard++;
        end
        if (done[0] && done[1]) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            report_failure("Master traffic did not finish within the run limit");
        end
    end

endmodule
